/* source/core_pkg.sv */
`default_nettype none

package core_pkg;

    localparam int DATA_W    = 32;
    localparam int ROB_DEPTH = 8;
    localparam int NUM_UNITS = 3;
    localparam int REG_W     = 5;                   // architectural register index
    localparam int TAG_W     = $clog2(ROB_DEPTH);
    localparam int UNIT_W    = $clog2(NUM_UNITS);   // round-robin pointer

    typedef logic [TAG_W-1:0] rob_tag_t;

    typedef enum logic [2:0] {
        op_lui,
        op_jal,
        op_add,
        op_xor,
        op_mul
    } op_kind_t;

    // operands arrive already read
    typedef struct packed {
        op_kind_t          kind;
        logic [DATA_W-1:0] pc;
        logic [REG_W-1:0]  rd;
        logic [DATA_W-1:0] imm;
        logic [DATA_W-1:0] src_a;
        logic [DATA_W-1:0] src_b;
    } issue_pkt_t;

    typedef struct packed {
        op_kind_t          kind;
        rob_tag_t          tag;
        logic [DATA_W-1:0] src_a;
        logic [DATA_W-1:0] src_b;
    } exec_req_t;

    typedef struct packed {
        rob_tag_t          tag;
        logic [DATA_W-1:0] value;
    } cdb_msg_t;

    typedef struct packed {
        logic [DATA_W-1:0] pc;
        logic [REG_W-1:0]  rd;
        logic [DATA_W-1:0] value;
        logic              redirect;   // jal only
        logic [DATA_W-1:0] target;
    } commit_t;

endpackage

`default_nettype wire

/* source/reorder_buffer.sv */
`timescale 1ns/100ps
`default_nettype none

module reorder_buffer (
    input  logic                 clk_in,
    input  logic                 rst_in,
    input  logic                 issue_valid,
    input  core_pkg::issue_pkt_t issue,
    output core_pkg::rob_tag_t   alloc_tag,
    output logic                 rob_full,
    input  logic                 cdb_valid,
    input  core_pkg::cdb_msg_t   cdb,
    output logic                 commit_valid,
    output core_pkg::commit_t    commit
);
    import core_pkg::*;

    rob_tag_t         head;
    rob_tag_t         tail;
    logic [TAG_W:0]   count;         // needs one extra bit for the full case

    logic [ROB_DEPTH-1:0] busy;
    logic [ROB_DEPTH-1:0] ready;

    // entry payload
    logic [DATA_W-1:0] ent_pc     [ROB_DEPTH];
    logic [REG_W-1:0]  ent_rd     [ROB_DEPTH];
    logic [DATA_W-1:0] ent_value  [ROB_DEPTH];
    logic [DATA_W-1:0] ent_target [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] ent_redirect;

    logic is_jal;
    logic value_known;               // lui and jal skip the units
    logic commit_fire;

    assign is_jal      = (issue.kind == op_jal);
    assign value_known = (issue.kind == op_lui) || is_jal;
    assign commit_fire = busy[head] && ready[head];

    assign alloc_tag = tail;         // dispatcher latches this on the issue edge
    assign rob_full  = (count == (TAG_W + 1)'(ROB_DEPTH));

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            busy         <= '0;
            ready        <= '0;
            commit_valid <= 1'b0;
        end else begin
            commit_valid <= commit_fire;

            if (issue_valid) begin
                busy[tail]  <= 1'b1;
                ready[tail] <= value_known;
                tail        <= tail + 1'b1;
            end

            // bus tag never matches the entry allocated this cycle
            if (cdb_valid) begin
                ready[cdb.tag] <= 1'b1;
            end

            if (commit_fire) begin
                busy[head]  <= 1'b0;
                ready[head] <= 1'b0;
                head        <= head + 1'b1;
            end

            count <= count + (TAG_W + 1)'(issue_valid) - (TAG_W + 1)'(commit_fire);
        end
    end

    always_ff @(posedge clk_in) begin
        if (issue_valid) begin
            ent_pc[tail]       <= issue.pc;
            ent_rd[tail]       <= issue.rd;
            ent_redirect[tail] <= is_jal;
            ent_target[tail]   <= is_jal ? issue.pc + issue.imm : '0;
            // computed kinds get overwritten from the bus
            ent_value[tail]    <= is_jal ? issue.pc + DATA_W'(4) : issue.imm;
        end

        if (cdb_valid) begin
            ent_value[cdb.tag] <= cdb.value;
        end

        if (commit_fire) begin
            commit.pc       <= ent_pc[head];
            commit.rd       <= ent_rd[head];
            commit.value    <= ent_value[head];
            commit.redirect <= ent_redirect[head];
            commit.target   <= ent_target[head];
        end
    end

endmodule

`default_nettype wire

/* source/dispatch_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module dispatch_unit (
    input  logic                              clk_in,
    input  logic                              rst_in,
    input  logic                              issue_valid,
    input  core_pkg::issue_pkt_t              issue,
    input  core_pkg::rob_tag_t                alloc_tag,
    input  logic                              rob_full,
    input  logic [core_pkg::NUM_UNITS-1:0]    unit_busy,
    output logic [core_pkg::NUM_UNITS-1:0]    start,
    output core_pkg::exec_req_t               req,
    output logic                              issue_ready
);
    import core_pkg::*;

    logic [NUM_UNITS-1:0] avail;
    logic [NUM_UNITS-1:0] pick;      // one-hot, lowest idle unit
    logic                 needs_unit;

    // a unit started this cycle only shows busy after the next edge
    assign avail = ~unit_busy & ~start;

    assign needs_unit = issue_valid && (issue.kind inside {op_add, op_xor, op_mul});

    always_comb begin
        pick = '0;
        for (int i = NUM_UNITS - 1; i >= 0; i--) begin
            if (avail[i]) begin
                pick    = '0;
                pick[i] = 1'b1;
            end
        end
    end

    assign issue_ready = !rob_full && (|avail);

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            start <= '0;
        end else begin
            start <= needs_unit ? pick : '0;   // one-cycle strobe
        end
    end

    // shared by all units, only the strobed one latches it
    always_ff @(posedge clk_in) begin
        if (needs_unit) begin
            req.kind  <= issue.kind;
            req.tag   <= alloc_tag;
            req.src_a <= issue.src_a;
            req.src_b <= issue.src_b;
        end
    end

endmodule

`default_nettype wire

/* source/exec_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module exec_unit (
    input  logic                clk_in,
    input  logic                rst_in,
    input  logic                start,
    input  core_pkg::exec_req_t req,
    input  logic                grant,
    output logic                busy,
    output logic                done,
    output core_pkg::cdb_msg_t  result
);
    import core_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_calc,     // shift-add loop
        st_hold      // waiting for the bus
    } state_t;

    state_t            state;
    logic [DATA_W-1:0] mcand;
    logic [DATA_W-1:0] mplier;
    logic [DATA_W-1:0] acc;
    logic [DATA_W-1:0] acc_next;
    logic              last_step;

    assign acc_next  = mplier[0] ? acc + mcand : acc;
    assign last_step = (mplier[DATA_W-1:1] == '0);   // no set bits left above bit 0
    assign busy      = (state != st_idle);

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state <= st_idle;
            done  <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        if (req.kind == op_mul && req.src_b != '0) begin
                            state <= st_calc;
                        end else begin
                            state <= st_hold;
                            done  <= 1'b1;
                        end
                    end
                end
                st_calc: begin
                    if (last_step) begin
                        state <= st_hold;
                        done  <= 1'b1;
                    end
                end
                st_hold: begin
                    if (grant) begin
                        state <= st_idle;
                        done  <= 1'b0;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        case (state)
            st_idle: begin
                if (start) begin
                    result.tag <= req.tag;
                    mcand      <= req.src_a;
                    mplier     <= req.src_b;
                    acc        <= '0;
                    case (req.kind)
                        op_add:  result.value <= req.src_a + req.src_b;
                        op_xor:  result.value <= req.src_a ^ req.src_b;
                        default: result.value <= '0;   // mul by zero stays 0
                    endcase
                end
            end
            st_calc: begin
                acc    <= acc_next;
                mcand  <= mcand << 1;
                mplier <= mplier >> 1;
                if (last_step) begin
                    result.value <= acc_next;
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* source/cdb_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module cdb_arbiter (
    input  logic                           clk_in,
    input  logic                           rst_in,
    input  logic [core_pkg::NUM_UNITS-1:0] done,
    input  core_pkg::cdb_msg_t             result [core_pkg::NUM_UNITS],
    output logic [core_pkg::NUM_UNITS-1:0] grant,
    output logic                           cdb_valid,
    output core_pkg::cdb_msg_t             cdb
);
    import core_pkg::*;

    logic [UNIT_W-1:0] ptr;     // first unit to look at
    logic [UNIT_W-1:0] sel;
    logic              found;

    always_comb begin
        int cand;
        sel   = ptr;
        found = 1'b0;
        for (int i = 0; i < NUM_UNITS; i++) begin
            cand = (int'(ptr) + i) % NUM_UNITS;
            if (!found && done[cand]) begin
                found = 1'b1;
                sel   = UNIT_W'(cand);
            end
        end
    end

    always_comb begin
        grant = '0;
        if (found) begin
            grant[sel] = 1'b1;
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            ptr       <= '0;
            cdb_valid <= 1'b0;
        end else begin
            cdb_valid <= found;
            if (found) begin
                ptr <= (sel == UNIT_W'(NUM_UNITS - 1)) ? '0 : sel + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (found) begin
            cdb <= result[sel];
        end
    end

endmodule

`default_nettype wire

/* source/ooo_backend.sv */
`timescale 1ns/100ps
`default_nettype none

module ooo_backend (
    input  logic                 clk_in,
    input  logic                 rst_in,
    input  logic                 issue_valid,
    input  core_pkg::issue_pkt_t issue,
    output logic                 issue_ready,
    output logic                 commit_valid,
    output core_pkg::commit_t    commit
);
    import core_pkg::*;

    rob_tag_t             alloc_tag;
    logic                 rob_full;
    logic [NUM_UNITS-1:0] unit_busy;
    logic [NUM_UNITS-1:0] unit_start;
    exec_req_t            unit_req;
    logic [NUM_UNITS-1:0] unit_done;
    cdb_msg_t             unit_result [NUM_UNITS];
    logic [NUM_UNITS-1:0] unit_grant;
    logic                 cdb_valid;
    cdb_msg_t             cdb;

    dispatch_unit u_dispatch (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .issue_valid (issue_valid),
        .issue       (issue),
        .alloc_tag   (alloc_tag),
        .rob_full    (rob_full),
        .unit_busy   (unit_busy),
        .start       (unit_start),
        .req         (unit_req),
        .issue_ready (issue_ready)
    );

    for (genvar gi = 0; gi < NUM_UNITS; gi++) begin : g_unit
        exec_unit u_exec (
            .clk_in (clk_in),
            .rst_in (rst_in),
            .start  (unit_start[gi]),
            .req    (unit_req),
            .grant  (unit_grant[gi]),
            .busy   (unit_busy[gi]),
            .done   (unit_done[gi]),
            .result (unit_result[gi])
        );
    end

    cdb_arbiter u_arbiter (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .done      (unit_done),
        .result    (unit_result),
        .grant     (unit_grant),
        .cdb_valid (cdb_valid),
        .cdb       (cdb)
    );

    reorder_buffer u_rob (
        .clk_in       (clk_in),
        .rst_in       (rst_in),
        .issue_valid  (issue_valid),
        .issue        (issue),
        .alloc_tag    (alloc_tag),
        .rob_full     (rob_full),
        .cdb_valid    (cdb_valid),
        .cdb          (cdb),
        .commit_valid (commit_valid),
        .commit       (commit)
    );

endmodule

`default_nettype wire

/* verif/ooo_backend_assertions.sv */
`timescale 1ns/100ps
`default_nettype none

module ooo_backend_assertions (
    input  logic                           clk_in,
    input  logic                           rst_in,
    input  logic [core_pkg::NUM_UNITS-1:0] grant,
    input  logic                           cdb_valid,
    input  core_pkg::rob_tag_t             cdb_tag,
    input  logic [core_pkg::ROB_DEPTH-1:0] busy,
    input  logic [core_pkg::ROB_DEPTH-1:0] ready,
    input  logic [core_pkg::TAG_W:0]       count
);
    import core_pkg::*;

    int fail_count = 0;   // read by the testbench at the end

    a_grant_onehot: assert property (@(posedge clk_in) disable iff (rst_in)
        $onehot0(grant))
        else begin
            $error("more than one unit granted the bus");
            fail_count++;
        end

    // write-back must land on a live entry still waiting for its value
    a_cdb_hit: assert property (@(posedge clk_in) disable iff (rst_in)
        cdb_valid |-> (busy[cdb_tag] && !ready[cdb_tag]))
        else begin
            $error("bus write to an entry that is free or already ready");
            fail_count++;
        end

    a_count_bound: assert property (@(posedge clk_in) disable iff (rst_in)
        count <= ROB_DEPTH)
        else begin
            $error("reorder buffer count above its depth");
            fail_count++;
        end

endmodule

bind reorder_buffer ooo_backend_assertions rob_chk (
    .clk_in    (clk_in),
    .rst_in    (rst_in),
    .grant     ('0),
    .cdb_valid (cdb_valid),
    .cdb_tag   (cdb.tag),
    .busy      (busy),
    .ready     (ready),
    .count     (count)
);

bind cdb_arbiter ooo_backend_assertions arb_chk (
    .clk_in    (clk_in),
    .rst_in    (rst_in),
    .grant     (grant),
    .cdb_valid (1'b0),
    .cdb_tag   ('0),
    .busy      ('0),
    .ready     ('0),
    .count     ('0)
);

`default_nettype wire

/* verif/ooo_backend_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module ooo_backend_tb;
    import core_pkg::*;

    localparam int N_RANDOM = 40;
    localparam int N_TOTAL  = 22 + N_RANDOM;   // directed, mul chain, burst, random

    logic       clk_in = 1'b0;
    logic       rst_in;
    logic       issue_valid;
    issue_pkt_t issue;
    logic       issue_ready;
    logic       commit_valid;
    commit_t    commit;

    commit_t     ref_q [$];
    commit_t     exp_c;
    logic [31:0] rng = 32'd78;
    logic [31:0] pc_next = 32'h0000_1000;
    int          errors = 0;
    int          max_out = 0;
    logic        ready_dropped = 1'b0;

    ooo_backend dut0 (
        .clk_in       (clk_in),
        .rst_in       (rst_in),
        .issue_valid  (issue_valid),
        .issue        (issue),
        .issue_ready  (issue_ready),
        .commit_valid (commit_valid),
        .commit       (commit)
    );

    always #50 clk_in = ~clk_in;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    function automatic issue_pkt_t make_pkt(input op_kind_t kind, input logic [31:0] imm,
                                            input logic [31:0] a, input logic [31:0] b);
        issue_pkt_t p;
        p.kind  = kind;
        p.pc    = '0;       // filled in at issue
        p.rd    = '0;
        p.imm   = imm;
        p.src_a = a;
        p.src_b = b;
        return p;
    endfunction

    function automatic commit_t expected_commit(input issue_pkt_t p);
        commit_t c;
        c.pc       = p.pc;
        c.rd       = p.rd;
        c.redirect = 1'b0;
        c.target   = '0;
        case (p.kind)
            op_lui: c.value = p.imm;
            op_jal: begin
                c.value    = p.pc + 32'd4;   // link address
                c.redirect = 1'b1;
                c.target   = p.pc + p.imm;
            end
            op_add:  c.value = p.src_a + p.src_b;
            op_xor:  c.value = p.src_a ^ p.src_b;
            default: c.value = p.src_a * p.src_b;   // low DATA_W bits only
        endcase
        return c;
    endfunction

    function automatic logic commit_matches(input commit_t got, input commit_t exp);
        return (got.pc === exp.pc) && (got.rd === exp.rd) && (got.value === exp.value)
            && (got.redirect === exp.redirect) && (!exp.redirect || got.target === exp.target);
    endfunction

    // called a short delay after a rising edge, returns at the same point
    task automatic send_issue(input issue_pkt_t pkt);
        while (!issue_ready) begin
            @(posedge clk_in);
            #1;
        end
        pkt.pc = pc_next;
        pkt.rd = REG_W'(pc_next >> 2);
        pc_next += 32'd4;
        issue       = pkt;
        issue_valid = 1'b1;
        ref_q.push_back(expected_commit(pkt));
        @(posedge clk_in);
        #1;
        issue_valid = 1'b0;
    endtask

    task automatic random_pkt(output issue_pkt_t p);
        op_kind_t    kind;
        logic [31:0] imm;
        logic [31:0] a;
        logic [31:0] b;
        kind = op_kind_t'(3'(next_rand() % 5));
        imm  = next_rand();
        a    = next_rand();
        b    = next_rand();
        if (kind == op_mul) begin
            b = b >> (next_rand() % 32);   // spread the multiply latency
        end
        p = make_pkt(kind, imm, a, b);
    endtask

    task automatic drain();
        while (ref_q.size() != 0) begin
            @(posedge clk_in);
            #1;
        end
    endtask

    always @(negedge clk_in) begin
        if (!rst_in) begin
            if (commit_valid) begin
                if (ref_q.size() == 0) begin
                    errors++;
                    $display("error at %0t: commit arrived with nothing outstanding", $time);
                end else begin
                    exp_c = ref_q.pop_front();
                    assert (commit_matches(commit, exp_c)) else begin
                        errors++;
                        $write("mismatch at %0t: pc %h rd %0d value %h redirect %b target %h",
                               $time, commit.pc, commit.rd, commit.value, commit.redirect,
                               commit.target);
                        $display(", expected pc %h rd %0d value %h redirect %b target %h",
                                 exp_c.pc, exp_c.rd, exp_c.value, exp_c.redirect, exp_c.target);
                    end
                end
            end
            assert (ref_q.size() <= ROB_DEPTH) else begin
                errors++;
                $display("mismatch at %0t: %0d outstanding, limit %0d",
                         $time, ref_q.size(), ROB_DEPTH);
            end
            if (ref_q.size() > max_out) max_out = ref_q.size();
            if (!issue_ready) ready_dropped = 1'b1;
        end
    end

    initial begin
        issue_pkt_t  pkt;
        logic [31:0] opa;
        int          assert_errors;
        rst_in      = 1'b1;
        issue_valid = 1'b0;
        issue       = '0;
        repeat (10) @(posedge clk_in);
        #1;
        rst_in = 1'b0;
        repeat (3) begin
            @(posedge clk_in);
            #1;
            assert (issue_ready && !commit_valid) else begin
                errors++;
                $display("error at %0t: idle after reset but issue_ready low or commit_valid high",
                         $time);
            end
        end

        send_issue(make_pkt(op_lui, 32'h1234_5000, '0, '0));
        send_issue(make_pkt(op_jal, 32'h0000_0100, '0, '0));
        send_issue(make_pkt(op_add, '0, 32'hffff_fff0, 32'h0000_0020));
        send_issue(make_pkt(op_xor, '0, 32'ha5a5_a5a5, 32'h0f0f_0f0f));
        send_issue(make_pkt(op_mul, '0, 32'h0001_0003, 32'h0000_0007));

        // adds finish early but must retire behind the long mul
        send_issue(make_pkt(op_mul, '0, 32'h0000_0003, 32'hffff_ffff));
        for (int i = 0; i < 4; i++) begin
            opa = next_rand();
            send_issue(make_pkt(op_add, '0, opa, next_rand()));
        end
        drain();

        ready_dropped = 1'b0;
        max_out       = 0;
        send_issue(make_pkt(op_mul, '0, 32'h0000_0005, 32'hffff_ffff));
        for (int i = 0; i < 11; i++) begin
            opa = next_rand();
            send_issue(make_pkt(op_mul, '0, opa, next_rand() & 32'hf));
        end
        assert (ready_dropped) else begin
            errors++;
            $display("error at %0t: issue_ready never dropped during the mul burst", $time);
        end
        assert (max_out == ROB_DEPTH) else begin
            errors++;
            $display("mismatch at %0t: peak outstanding %0d, expected %0d",
                     $time, max_out, ROB_DEPTH);
        end

        for (int i = 0; i < N_RANDOM; i++) begin
            random_pkt(pkt);
            send_issue(pkt);
        end
        drain();
        repeat (5) @(posedge clk_in);   // catch stray commits

        assert_errors = dut0.u_rob.rob_chk.fail_count + dut0.u_arbiter.arb_chk.fail_count;
        $display("errors: %0d compare, %0d assertion", errors, assert_errors);
        if (errors == 0 && assert_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        repeat (N_TOTAL * 40) @(posedge clk_in);
        $display("timeout: DUT hung with %0d instructions still waiting to commit",
                 ref_q.size());
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* ooo_backend.f */
source/core_pkg.sv
source/reorder_buffer.sv
source/dispatch_unit.sv
source/exec_unit.sv
source/cdb_arbiter.sv
source/ooo_backend.sv
verif/ooo_backend_assertions.sv
verif/ooo_backend_tb.sv
